//--- design/hdc_pkg.sv
`default_nettype none

package hdc_pkg;

    // Class set
    localparam int NUM_CLASSES = 26;
    localparam int CLASS_W     = 5;

    // Hypervector geometry
    localparam int HV_DIM       = 128;
    localparam int WORD_W       = 32;
    localparam int WORDS_PER_HV = HV_DIM / WORD_W;
    localparam int WORD_SEL_W   = $clog2(WORDS_PER_HV); // Word index within a class

    // Class memory, class c word w at c*4+w
    localparam int MEM_DEPTH = NUM_CLASSES * WORDS_PER_HV;
    localparam int ADDR_W    = $clog2(MEM_DEPTH);

    // Sized for 5k-dim hypervectors
    localparam int SIM_W = 13;

    typedef enum logic [2:0] {
        IDLE,   // Waiting for first query word
        GATHER, // Collecting remaining query words
        SCAN,   // Issuing class memory reads
        DRAIN,  // Last read data in flight
        DONE    // Similarities final
    } engine_state_t;

endpackage

`default_nettype wire

//--- design/am_bus_if.sv
`default_nettype none

interface am_bus_if
    import hdc_pkg::*;
();

    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    logic              gnt;
    logic [WORD_W-1:0] rdata;   // Valid the cycle after a read gnt

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

//--- design/am_class_memory.sv
`default_nettype none

module am_class_memory
    import hdc_pkg::*;
(
    input  logic      clk,
    am_bus_if.arbiter bus
);

    logic [WORD_W-1:0] mem [MEM_DEPTH];
    logic [WORD_W-1:0] rdata_q;

    // Single port target, always ready
    assign bus.gnt = bus.req;

    always_ff @(posedge clk) begin
        if (bus.gnt && bus.we) begin
            mem[bus.addr] <= bus.wdata;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (bus.gnt && !bus.we) begin
            rdata_q <= mem[bus.addr];
        end
    end

    assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- design/am_arbiter.sv
`default_nettype none

module am_arbiter
    import hdc_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    am_bus_if.arbiter   load_bus,
    am_bus_if.arbiter   eng_bus,
    am_bus_if.requester mem_bus
);

    logic load_rd_q;    // Load port owns the returning rdata
    logic eng_rd_q;     // Engine owns the returning rdata

    // Load port always wins
    assign load_bus.gnt = load_bus.req && mem_bus.gnt;
    assign eng_bus.gnt  = eng_bus.req && !load_bus.req && mem_bus.gnt;

    assign mem_bus.req   = load_bus.req || eng_bus.req;
    assign mem_bus.we    = load_bus.req ? load_bus.we    : eng_bus.we;
    assign mem_bus.addr  = load_bus.req ? load_bus.addr  : eng_bus.addr;
    assign mem_bus.wdata = load_bus.req ? load_bus.wdata : eng_bus.wdata;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            load_rd_q <= 1'b0;
            eng_rd_q  <= 1'b0;
        end else begin
            load_rd_q <= load_bus.gnt && !load_bus.we;
            eng_rd_q  <= eng_bus.gnt && !eng_bus.we;
        end
    end

    // Steer read data back to whoever issued it
    assign load_bus.rdata = load_rd_q ? mem_bus.rdata : '0;
    assign eng_bus.rdata  = eng_rd_q  ? mem_bus.rdata : '0;

endmodule

`default_nettype wire

//--- design/am_similarity_engine.sv
`default_nettype none

module am_similarity_engine
    import hdc_pkg::*;
(
    input  logic              clk,
    input  logic              nrst,
    input  logic              query_valid,
    input  logic [WORD_W-1:0] query_data,
    am_bus_if.requester       mem,
    output logic              compare_strobe,
    output logic [SIM_W-1:0]  similarity_values [NUM_CLASSES]
);

    engine_state_t         state;
    logic [WORD_SEL_W-1:0] q_cnt;                        // Next query word slot
    logic [WORD_W-1:0]     query_words [WORDS_PER_HV];
    logic [ADDR_W-1:0]     scan_addr;
    logic                  read_gnt;
    logic                  last_addr;
    logic                  query_accept;
    logic                  rd_valid_q;                   // Read data arrives this cycle
    logic [CLASS_W-1:0]    rd_class_q;
    logic [WORD_SEL_W-1:0] rd_word_q;

    // Number of equal bits between two words
    function automatic logic [SIM_W-1:0] count_equal(input logic [WORD_W-1:0] a,
                                                     input logic [WORD_W-1:0] b);
        logic [SIM_W-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < WORD_W; i++) begin
            cnt = cnt + SIM_W'(a[i] ~^ b[i]);
        end
        return cnt;
    endfunction

    assign query_accept = query_valid && (state == IDLE || state == GATHER);
    assign read_gnt     = mem.req && mem.gnt;
    assign last_addr    = scan_addr == ADDR_W'(MEM_DEPTH - 1);

    // Read only requester
    assign mem.req   = state == SCAN;
    assign mem.we    = 1'b0;
    assign mem.addr  = scan_addr;
    assign mem.wdata = '0;

    assign compare_strobe = state == DONE;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state     <= IDLE;
            q_cnt     <= '0;
            scan_addr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (query_valid) begin
                        q_cnt <= q_cnt + 1'b1;
                        state <= GATHER;
                    end
                end
                GATHER: begin
                    if (query_valid) begin
                        q_cnt <= q_cnt + 1'b1;  // Wraps back to 0 after last word
                        if (q_cnt == WORD_SEL_W'(WORDS_PER_HV - 1)) begin
                            scan_addr <= '0;
                            state     <= SCAN;
                        end
                    end
                end
                SCAN: begin
                    if (read_gnt) begin   // Hold address while load port owns memory
                        scan_addr <= scan_addr + 1'b1;
                        if (last_addr) state <= DRAIN;
                    end
                end
                DRAIN:   state <= DONE;
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (query_accept) query_words[q_cnt] <= query_data;
    end

    // Track class and word of the read in flight
    always_ff @(posedge clk) begin
        if (!nrst) rd_valid_q <= 1'b0;
        else       rd_valid_q <= read_gnt;
    end

    always_ff @(posedge clk) begin
        if (read_gnt) begin
            rd_class_q <= scan_addr[ADDR_W-1:WORD_SEL_W];
            rd_word_q  <= scan_addr[WORD_SEL_W-1:0];
        end
    end

    // Per-class accumulators
    always_ff @(posedge clk) begin
        if (state == IDLE && query_valid) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                similarity_values[c] <= '0;
            end
        end else if (rd_valid_q) begin
            similarity_values[rd_class_q] <= similarity_values[rd_class_q] +
                                             count_equal(mem.rdata, query_words[rd_word_q]);
        end
    end

endmodule

`default_nettype wire

//--- design/am_tree_comparator.sv
`default_nettype none

module am_tree_comparator
    import hdc_pkg::*;
(
    input  logic               clk,
    input  logic               nrst,
    input  logic               compare_strobe,
    input  logic [SIM_W-1:0]   similarity_values [NUM_CLASSES],
    output logic               result_valid,
    output logic [CLASS_W-1:0] class_inference
);

    logic [SIM_W-1:0]   sim_0 [NUM_CLASSES/2];    // 13 pairs
    logic [SIM_W-1:0]   sim_1 [NUM_CLASSES/4];
    logic [SIM_W-1:0]   sim_2 [NUM_CLASSES/8];
    logic [SIM_W-1:0]   sim_3 [2];
    logic [CLASS_W-1:0] cls_0 [NUM_CLASSES/2];
    logic [CLASS_W-1:0] cls_1 [NUM_CLASSES/4];
    logic [CLASS_W-1:0] cls_2 [NUM_CLASSES/8];
    logic [CLASS_W-1:0] cls_3 [2];
    logic [CLASS_W-1:0] winner;

    // Ties keep the left, lower index side throughout
    always_comb begin
        for (int i = 0; i < NUM_CLASSES/2; i++) begin
            if (similarity_values[2*i] >= similarity_values[2*i+1]) begin
                sim_0[i] = similarity_values[2*i];
                cls_0[i] = CLASS_W'(2*i);
            end else begin
                sim_0[i] = similarity_values[2*i+1];
                cls_0[i] = CLASS_W'(2*i+1);
            end
        end
        for (int i = 0; i < NUM_CLASSES/4; i++) begin
            sim_1[i] = sim_0[2*i] >= sim_0[2*i+1] ? sim_0[2*i] : sim_0[2*i+1];
            cls_1[i] = sim_0[2*i] >= sim_0[2*i+1] ? cls_0[2*i] : cls_0[2*i+1];
        end
        for (int i = 0; i < NUM_CLASSES/8; i++) begin
            sim_2[i] = sim_1[2*i] >= sim_1[2*i+1] ? sim_1[2*i] : sim_1[2*i+1];
            cls_2[i] = sim_1[2*i] >= sim_1[2*i+1] ? cls_1[2*i] : cls_1[2*i+1];
        end
        sim_3[0] = sim_2[0] >= sim_2[1] ? sim_2[0] : sim_2[1];
        cls_3[0] = sim_2[0] >= sim_2[1] ? cls_2[0] : cls_2[1];
        // Pair 12 (classes 24, 25) skips levels 1 and 2
        sim_3[1] = sim_2[2] >= sim_0[NUM_CLASSES/2-1] ? sim_2[2] : sim_0[NUM_CLASSES/2-1];
        cls_3[1] = sim_2[2] >= sim_0[NUM_CLASSES/2-1] ? cls_2[2] : cls_0[NUM_CLASSES/2-1];
        winner   = sim_3[0] >= sim_3[1] ? cls_3[0] : cls_3[1];
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            result_valid    <= 1'b0;
            class_inference <= '0;
        end else begin
            result_valid <= compare_strobe;
            if (compare_strobe) class_inference <= winner;  // Held until next strobe
        end
    end

endmodule

`default_nettype wire

//--- design/am_classifier_top.sv
`default_nettype none

module am_classifier_top
    import hdc_pkg::*;
(
    input  logic               clk,
    input  logic               nrst,
    input  logic               load_valid,
    input  logic [ADDR_W-1:0]  load_addr,
    input  logic [WORD_W-1:0]  load_data,
    input  logic               query_valid,
    input  logic [WORD_W-1:0]  query_data,
    output logic               result_valid,
    output logic [CLASS_W-1:0] class_inference
);

    am_bus_if load_if ();   // Host load port
    am_bus_if eng_if ();    // Similarity engine
    am_bus_if mem_if ();    // Arbiter to class memory

    logic               compare_strobe;
    logic [SIM_W-1:0]   similarity_values [NUM_CLASSES];

    // Load strobe is a write request, never refused
    assign load_if.req   = load_valid;
    assign load_if.we    = load_valid;
    assign load_if.addr  = load_addr;
    assign load_if.wdata = load_data;

    am_arbiter i_am_arbiter (
        .clk      (clk),
        .nrst     (nrst),
        .load_bus (load_if.arbiter),
        .eng_bus  (eng_if.arbiter),
        .mem_bus  (mem_if.requester)
    );

    am_class_memory i_am_class_memory (
        .clk (clk),
        .bus (mem_if.arbiter)
    );

    am_similarity_engine i_am_similarity_engine (
        .clk               (clk),
        .nrst              (nrst),
        .query_valid       (query_valid),
        .query_data        (query_data),
        .mem               (eng_if.requester),
        .compare_strobe    (compare_strobe),
        .similarity_values (similarity_values)
    );

    am_tree_comparator i_am_tree_comparator (
        .clk               (clk),
        .nrst              (nrst),
        .compare_strobe    (compare_strobe),
        .similarity_values (similarity_values),
        .result_valid      (result_valid),
        .class_inference   (class_inference)
    );

endmodule

`default_nettype wire

//--- testbench/am_classifier_tb.sv
`default_nettype none

module am_classifier_tb
    import hdc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY = 107;  // Fourth query strobe to result_valid, idle bus
    localparam int WINDOW  = 300;  // Cycles allowed for one result

    logic               clk;
    logic               nrst;
    logic               load_valid;
    logic [ADDR_W-1:0]  load_addr;
    logic [WORD_W-1:0]  load_data;
    logic               query_valid;
    logic [WORD_W-1:0]  query_data;
    logic               result_valid;
    logic [CLASS_W-1:0] class_inference;

    logic [WORD_W-1:0] mem_model [MEM_DEPTH];  // Mirror of class memory
    bit                t_reload [$];
    int                t_src [$];
    int                t_flips [$];
    int                t_exp [$];
    int                t_load [$];
    int                t_target [$];
    int                cycles = 0;
    int                limit = 0;
    int                errors = 0;
    int                tests_bad = 0;

    am_classifier_top i_am_classifier_top (
        .clk             (clk),
        .nrst            (nrst),
        .load_valid      (load_valid),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .query_valid     (query_valid),
        .query_data      (query_data),
        .result_valid    (result_valid),
        .class_inference (class_inference)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin : watchdog
        engine_state_t st;
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            st = i_am_classifier_top.i_am_similarity_engine.state;
            $display("Run stopped after %0d cycles, engine in %s", cycles, st.name());
            $display("Regression failed");
            $finish;
        end
    end

    task automatic load_patterns(output bit ok);
        int            fd;
        int            n;
        int            src;
        int            flips;
        int            exp_cls;
        int            load;
        int            target;
        logic [1023:0] line;
        logic [63:0]   kind;
        ok = 1'b0;
        fd = $fopen("testbench/am_patterns.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            line = '0;
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %d %d %d %d %d", kind, src, flips, exp_cls, load, target);
                if (n == 6) begin  // Comment and blank lines skipped
                    if (kind != "infer" && kind != "reload") ok = 1'b0;
                    t_reload.push_back(kind == "reload");
                    t_src.push_back(src);
                    t_flips.push_back(flips);
                    t_exp.push_back(exp_cls);
                    t_load.push_back(load);
                    t_target.push_back(target);
                end
                line = '0;
            end
            $fclose(fd);
            if (t_src.size() == 0) ok = 1'b0;
        end
    endtask

    function automatic logic [HV_DIM-1:0] class_hv(input int c);
        logic [HV_DIM-1:0] hv;
        for (int w = 0; w < WORDS_PER_HV; w++) begin
            hv[w*WORD_W +: WORD_W] = mem_model[c*WORDS_PER_HV + w];
        end
        return hv;
    endfunction

    // Most equal bits wins, lower index on a tie
    function automatic int best_class(input logic [HV_DIM-1:0] q);
        int best;
        int best_sim;
        int sim;
        best     = 0;
        best_sim = -1;
        for (int c = 0; c < NUM_CLASSES; c++) begin
            sim = HV_DIM - $countones(q ^ class_hv(c));
            if (sim > best_sim) begin
                best_sim = sim;
                best     = c;
            end
        end
        return best;
    endfunction

    task automatic write_word(input int addr, input logic [WORD_W-1:0] data);
        @(posedge clk);
        load_valid <= 1'b1;
        load_addr  <= ADDR_W'(addr);
        load_data  <= data;
        mem_model[addr] = data;
    endtask

    task automatic send_query(input logic [HV_DIM-1:0] q);
        for (int w = 0; w < WORDS_PER_HV; w++) begin
            @(posedge clk);
            load_valid  <= 1'b0;
            query_valid <= 1'b1;
            query_data  <= q[w*WORD_W +: WORD_W];
        end
    endtask

    task automatic run_test(input int t);
        logic [HV_DIM-1:0] q;
        int                pos;
        int                model_cls;
        int                lat;
        int                pulses;
        int                seen_at;
        int                got_cls;
        int                addr;
        int                err_start;
        err_start = errors;
        q = class_hv(t_src[t]);
        repeat (t_flips[t]) begin
            pos    = $urandom % HV_DIM;
            q[pos] = ~q[pos];
        end
        if (t_reload[t]) begin  // Query vector becomes the target class
            for (int w = 0; w < WORDS_PER_HV; w++) begin
                write_word(t_target[t]*WORDS_PER_HV + w, q[w*WORD_W +: WORD_W]);
            end
        end
        model_cls = best_class(q);
        if (model_cls != t_exp[t]) begin
            $display("Pattern file expects class %0d but the model gives %0d",
                     t_exp[t], model_cls);
            errors++;
        end
        send_query(q);
        lat     = 0;
        pulses  = 0;
        seen_at = 0;
        got_cls = 0;
        while (lat < WINDOW && (pulses == 0 || lat < seen_at + 3)) begin
            @(posedge clk);
            query_valid <= 1'b0;
            if (t_load[t] != 0 && pulses == 0 && lat % 3 == 0) begin
                addr       = $urandom % MEM_DEPTH;
                load_valid <= 1'b1;
                load_addr  <= ADDR_W'(addr);
                load_data  <= mem_model[addr];  // Same value as stored
            end else begin
                load_valid <= 1'b0;
            end
            @(negedge clk);
            lat++;
            if (result_valid) begin
                pulses++;
                if (pulses == 1) begin
                    seen_at = lat;
                    got_cls = class_inference;
                end
            end
        end
        if (pulses == 0) begin
            $display("No result_valid within %0d cycles of the query", WINDOW);
            errors++;
        end else if (got_cls != t_exp[t]) begin
            $display("** Error at %0t ns: class_inference = %0d, expected %0d",
                     $time, got_cls, t_exp[t]);
            errors++;
        end
        if (pulses > 1) begin
            $display("result_valid pulsed %0d times for one query", pulses);
            errors++;
        end
        if (t_load[t] == 0 && pulses > 0 && seen_at != LATENCY) begin
            $display("** Error at %0t ns: result_valid latency = %0d, expected %0d",
                     $time, seen_at, LATENCY);
            errors++;
        end
        if (errors != err_start) tests_bad++;
        $display("Test %0d %s class %0d flips %0d load %0d: got %0d, %s", t,
                 t_reload[t] ? "reload" : "infer", t_src[t], t_flips[t], t_load[t],
                 got_cls, errors == err_start ? "ok" : "FAIL");
    endtask

    initial begin
        bit file_ok;
        nrst        = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        query_valid = 1'b0;
        query_data  = '0;
        void'($urandom(32'h23bb_4293));
        load_patterns(file_ok);
        if (!file_ok) begin
            $display("Pattern file testbench/am_patterns.txt is missing or malformed");
            $display("Regression failed");
            $finish;
        end else begin
            limit = t_src.size() * 400 + 200;
            for (int a = 0; a < MEM_DEPTH; a++) begin
                mem_model[a] = $urandom;
            end
            repeat (16) @(posedge clk);
            nrst <= 1'b1;
            for (int a = 0; a < MEM_DEPTH; a++) begin
                write_word(a, mem_model[a]);
            end
            @(posedge clk);
            load_valid <= 1'b0;
            for (int t = 0; t < t_src.size(); t++) begin
                run_test(t);
            end
            $display("%0d tests, %0d with errors, %0d errors in total",
                     t_src.size(), tests_bad, errors);
            if (errors == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- testbench/am_patterns.txt
# kind src flips expect load target
# reload writes the query into class target, then infers
infer   0   0  0   0  0
infer   12  0  12  0  0
infer   24  0  24  0  0
infer   25  0  25  0  0
infer   7   0  7   0  0
infer   19  0  19  0  0
infer   1   5  1   0  0
infer   13  12 13  0  0
infer   22  20 22  0  0
infer   25  17 25  0  0
infer   4   0  4   1  0
infer   16  9  16  1  0
infer   24  3  24  1  0
reload  5   6  9   0  9
infer   5   0  5   0  0
reload  3   0  3   0  17
infer   17  0  3   0  0

//--- filelist.f
design/hdc_pkg.sv
design/am_bus_if.sv
design/am_class_memory.sv
design/am_arbiter.sv
design/am_similarity_engine.sv
design/am_tree_comparator.sv
design/am_classifier_top.sv
testbench/am_classifier_tb.sv

//--- Makefile
# Verilator build of the associative memory classifier testbench
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module am_classifier_tb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vam_classifier_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
